/* source/axi_lite_slave.sv */
module axi_lite_slave #(
	parameter logic [31:0] UART_BASE_ADDR = 32'h2000_0000
) (
	input  logic                    s_axi_aclk_i,
	input  logic                    s_axi_aresetn_i,
	input  logic [31:0]             s_axi_awaddr_i,
	input  logic                    s_axi_awvalid_i,
	input  logic [31:0]             s_axi_wdata_i,
	input  logic [3:0]              s_axi_wstrb_i,
	input  logic                    s_axi_wvalid_i,
	input  logic                    s_axi_bready_i,
	output logic                    s_axi_awready_o,
	output logic                    s_axi_wready_o,
	output logic                    s_axi_bvalid_o,
	output uart_axi_pkg::axi_resp_t s_axi_bresp_o,
	input  logic [31:0]             s_axi_araddr_i,
	input  logic                    s_axi_arvalid_i,
	input  logic                    s_axi_rready_i,
	output logic                    s_axi_arready_o,
	output logic                    s_axi_rvalid_o,
	output logic [31:0]             s_axi_rdata_o,
	output uart_axi_pkg::axi_resp_t s_axi_rresp_o,
	input  logic [31:0]             rd_data_i,
	input  logic                    wr_err_i,
	input  logic                    rd_err_i,
	output logic                    wr_stb_o,
	output uart_axi_pkg::reg_idx_t  wr_idx_o,
	output logic [31:0]             wr_data_o,
	output logic [3:0]              wr_strb_o,
	output logic                    rd_stb_o,
	output uart_axi_pkg::reg_idx_t  rd_idx_o
);
	import uart_axi_pkg::*;

	logic wr_busy_q; // set from accept until b handshake
	logic rd_busy_q;
	logic aw_hit_q;
	logic ar_hit_q;
	logic wr_accept;
	logic rd_accept;

	assign wr_accept = s_axi_awvalid_i & s_axi_wvalid_i & ~wr_busy_q;
	assign rd_accept = s_axi_arvalid_i & ~rd_busy_q;

	// strobes share the ready pulse cycle
	assign wr_stb_o = s_axi_awready_o & aw_hit_q;
	assign rd_stb_o = s_axi_arready_o & ar_hit_q;

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			wr_busy_q       <= 1'b0;
			s_axi_awready_o <= 1'b0;
			s_axi_wready_o  <= 1'b0;
			s_axi_bvalid_o  <= 1'b0;
		end else begin
			s_axi_awready_o <= wr_accept;
			s_axi_wready_o  <= wr_accept;
			if (wr_accept)
				wr_busy_q <= 1'b1;
			else if (s_axi_bvalid_o && s_axi_bready_i)
				wr_busy_q <= 1'b0;
			if (s_axi_awready_o)
				s_axi_bvalid_o <= 1'b1;
			else if (s_axi_bready_i)
				s_axi_bvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (wr_accept) begin
			aw_hit_q  <= (s_axi_awaddr_i & ~32'hF) == UART_BASE_ADDR;
			wr_idx_o  <= s_axi_awaddr_i[3:2];
			wr_data_o <= s_axi_wdata_i;
			wr_strb_o <= s_axi_wstrb_i;
		end
		if (s_axi_awready_o)
			s_axi_bresp_o <= (!aw_hit_q || wr_err_i) ? RESP_SLVERR : RESP_OKAY;
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			rd_busy_q       <= 1'b0;
			s_axi_arready_o <= 1'b0;
			s_axi_rvalid_o  <= 1'b0;
		end else begin
			s_axi_arready_o <= rd_accept;
			if (rd_accept)
				rd_busy_q <= 1'b1;
			else if (s_axi_rvalid_o && s_axi_rready_i)
				rd_busy_q <= 1'b0;
			if (s_axi_arready_o)
				s_axi_rvalid_o <= 1'b1;
			else if (s_axi_rready_i)
				s_axi_rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (rd_accept) begin
			ar_hit_q <= (s_axi_araddr_i & ~32'hF) == UART_BASE_ADDR;
			rd_idx_o <= s_axi_araddr_i[3:2];
		end
		if (s_axi_arready_o) begin
			s_axi_rdata_o <= ar_hit_q ? rd_data_i : 32'd0; // zero outside window
			s_axi_rresp_o <= (!ar_hit_q || rd_err_i) ? RESP_SLVERR : RESP_OKAY;
		end
	end

endmodule

/* source/byte_fifo.sv */
module byte_fifo #(
	parameter int unsigned FIFO_DEPTH = 32
) (
	input  logic       s_axi_aclk_i,
	input  logic       s_axi_aresetn_i,
	input  logic       push_i,
	input  logic [7:0] push_data_i,
	input  logic       pop_i,
	output logic [7:0] head_o,
	output logic       empty_o,
	output logic       full_o
);
	localparam int unsigned AW = $clog2(FIFO_DEPTH);

	logic [7:0]  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr_q; // extra msb tells wrap
	logic [AW:0] rd_ptr_q;
	logic        push_ok;
	logic        pop_ok;

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
		(wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

	assign push_ok = push_i && !full_o;  // ignored when full
	assign pop_ok  = pop_i && !empty_o;

	assign head_o = mem[rd_ptr_q[AW-1:0]];

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push_ok)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_ok)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (push_ok)
			mem[wr_ptr_q[AW-1:0]] <= push_data_i;
	end

endmodule

/* source/uart_axi_pkg.sv */
package uart_axi_pkg;

	// register index is address bits 3:2
	typedef logic [1:0] reg_idx_t;

	localparam reg_idx_t REG_CTRL   = 2'd0; // 0x0
	localparam reg_idx_t REG_STATUS = 2'd1; // 0x4
	localparam reg_idx_t REG_RDATA  = 2'd2; // 0x8
	localparam reg_idx_t REG_WDATA  = 2'd3; // 0xC

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// control register bits
	localparam int CTRL_TX_EN = 0;
	localparam int CTRL_RX_EN = 1;

	// status register bits
	localparam int ST_RX_EMPTY = 3;
	localparam int ST_RX_FULL  = 2;
	localparam int ST_TX_EMPTY = 1;
	localparam int ST_TX_FULL  = 0;

endpackage

/* source/uart_axi_top.sv */
module uart_axi_top #(
	parameter logic [31:0] UART_BASE_ADDR = 32'h2000_0000,
	parameter int unsigned FIFO_DEPTH     = 32
) (
	input  logic                    s_axi_aclk_i,
	input  logic                    s_axi_aresetn_i,
	input  logic [31:0]             s_axi_awaddr_i,
	input  logic                    s_axi_awvalid_i,
	input  logic [31:0]             s_axi_wdata_i,
	input  logic [3:0]              s_axi_wstrb_i,
	input  logic                    s_axi_wvalid_i,
	input  logic                    s_axi_bready_i,
	output logic                    s_axi_awready_o,
	output logic                    s_axi_wready_o,
	output logic                    s_axi_bvalid_o,
	output uart_axi_pkg::axi_resp_t s_axi_bresp_o,
	input  logic [31:0]             s_axi_araddr_i,
	input  logic                    s_axi_arvalid_i,
	input  logic                    s_axi_rready_i,
	output logic                    s_axi_arready_o,
	output logic                    s_axi_rvalid_o,
	output logic [31:0]             s_axi_rdata_o,
	output uart_axi_pkg::axi_resp_t s_axi_rresp_o,
	input  logic                    t_done_i,
	input  logic                    r_done_i,
	input  logic [7:0]              rx_i,
	output logic                    tx_en_o,
	output logic                    rx_en_o,
	output logic [7:0]              tx_o,
	output logic [15:0]             baud_div_o
);
	import uart_axi_pkg::*;

	logic        wr_stb;
	reg_idx_t    wr_idx;
	logic [31:0] wr_data;
	logic [3:0]  wr_strb;
	logic        rd_stb;
	reg_idx_t    rd_idx;
	logic [31:0] rd_data;
	logic        wr_err;
	logic        rd_err;
	logic        tx_push, tx_pop, rx_push, rx_pop;
	logic [7:0]  push_byte;
	logic [7:0]  tx_head, rx_head;
	logic        tx_empty, tx_full, rx_empty, rx_full;

	axi_lite_slave #(.UART_BASE_ADDR(UART_BASE_ADDR)) u_slave (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_wdata_i, .s_axi_wstrb_i,
		.s_axi_wvalid_i, .s_axi_bready_i, .s_axi_awready_o, .s_axi_wready_o,
		.s_axi_bvalid_o, .s_axi_bresp_o, .s_axi_araddr_i, .s_axi_arvalid_i,
		.s_axi_rready_i, .s_axi_arready_o, .s_axi_rvalid_o, .s_axi_rdata_o,
		.s_axi_rresp_o, .rd_data_i(rd_data), .wr_err_i(wr_err), .rd_err_i(rd_err),
		.wr_stb_o(wr_stb), .wr_idx_o(wr_idx), .wr_data_o(wr_data), .wr_strb_o(wr_strb),
		.rd_stb_o(rd_stb), .rd_idx_o(rd_idx)
	);

	uart_regs u_regs (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.wr_stb_i(wr_stb), .wr_idx_i(wr_idx), .wr_data_i(wr_data), .wr_strb_i(wr_strb),
		.rd_stb_i(rd_stb), .rd_idx_i(rd_idx), .t_done_i, .r_done_i, .rx_i,
		.tx_head_i(tx_head), .tx_empty_i(tx_empty), .tx_full_i(tx_full),
		.rx_head_i(rx_head), .rx_empty_i(rx_empty), .rx_full_i(rx_full),
		.wr_err_o(wr_err), .rd_err_o(rd_err), .rd_data_o(rd_data),
		.tx_push_o(tx_push), .tx_pop_o(tx_pop), .rx_push_o(rx_push), .rx_pop_o(rx_pop),
		.push_byte_o(push_byte), .tx_en_o, .rx_en_o, .tx_o, .baud_div_o
	);

	byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.push_i(tx_push), .push_data_i(push_byte), .pop_i(tx_pop),
		.head_o(tx_head), .empty_o(tx_empty), .full_o(tx_full)
	);

	byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.push_i(rx_push), .push_data_i(push_byte), .pop_i(rx_pop),
		.head_o(rx_head), .empty_o(rx_empty), .full_o(rx_full)
	);

endmodule

/* source/uart_regs.sv */
module uart_regs (
	input  logic                   s_axi_aclk_i,
	input  logic                   s_axi_aresetn_i,
	input  logic                   wr_stb_i,
	input  uart_axi_pkg::reg_idx_t wr_idx_i,
	input  logic [31:0]            wr_data_i,
	input  logic [3:0]             wr_strb_i,
	input  logic                   rd_stb_i,
	input  uart_axi_pkg::reg_idx_t rd_idx_i,
	input  logic                   t_done_i,
	input  logic                   r_done_i,
	input  logic [7:0]             rx_i,
	input  logic [7:0]             tx_head_i,
	input  logic                   tx_empty_i,
	input  logic                   tx_full_i,
	input  logic [7:0]             rx_head_i,
	input  logic                   rx_empty_i,
	input  logic                   rx_full_i,
	output logic                   wr_err_o,
	output logic                   rd_err_o,
	output logic [31:0]            rd_data_o,
	output logic                   tx_push_o,
	output logic                   tx_pop_o,
	output logic                   rx_push_o,
	output logic                   rx_pop_o,
	output logic [7:0]             push_byte_o,
	output logic                   tx_en_o,
	output logic                   rx_en_o,
	output logic [7:0]             tx_o,
	output logic [15:0]            baud_div_o
);
	import uart_axi_pkg::*;

	logic [31:0] ctrl_q;
	logic [3:0]  status;
	logic        tx_pop_q; // pop seen last cycle
	logic        rx_push_q;

	assign tx_en_o    = ctrl_q[CTRL_TX_EN];
	assign rx_en_o    = ctrl_q[CTRL_RX_EN];
	assign baud_div_o = ctrl_q[31:16];
	assign tx_o       = tx_head_i; // uart sends the head byte

	always_comb begin
		status              = '0;
		status[ST_RX_EMPTY] = rx_empty_i;
		status[ST_RX_FULL]  = rx_full_i;
		status[ST_TX_EMPTY] = tx_empty_i;
		status[ST_TX_FULL]  = tx_full_i;
	end

	// legality of the access at the current index
	assign wr_err_o = (wr_idx_i == REG_STATUS) || (wr_idx_i == REG_RDATA) ||
		((wr_idx_i == REG_WDATA) && tx_full_i);
	assign rd_err_o = (rd_idx_i == REG_WDATA) || ((rd_idx_i == REG_RDATA) && rx_empty_i);

	always_comb begin
		case (rd_idx_i)
			REG_CTRL:   rd_data_o = ctrl_q;
			REG_STATUS: rd_data_o = {28'd0, status};
			REG_RDATA:  rd_data_o = {24'd0, rx_head_i};
			default:    rd_data_o = 32'd0;
		endcase
	end

	assign tx_push_o = wr_stb_i && (wr_idx_i == REG_WDATA) && !tx_full_i;
	assign rx_pop_o  = rd_stb_i && (rd_idx_i == REG_RDATA) && !rx_empty_i;
	assign tx_pop_o  = t_done_i && tx_en_o && !tx_empty_i;
	assign rx_push_o = r_done_i && rx_en_o && !rx_full_i;

	// pushes go to different buffers
	assign push_byte_o = rx_push_o ? rx_i : wr_data_i[7:0];

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			ctrl_q    <= 32'd0;
			tx_pop_q  <= 1'b0;
			rx_push_q <= 1'b0;
		end else begin
			tx_pop_q  <= tx_pop_o;
			rx_push_q <= rx_push_o;
			if (wr_stb_i && (wr_idx_i == REG_CTRL)) begin
				for (int b = 0; b < 4; b++) begin
					if (wr_strb_i[b])
						ctrl_q[8*b +: 8] <= wr_data_i[8*b +: 8];
				end
			end
			// flags settle a cycle after the buffer update
			if (tx_pop_q && tx_empty_i)
				ctrl_q[CTRL_TX_EN] <= 1'b0; // last byte gone
			if (rx_push_q && rx_full_i)
				ctrl_q[CTRL_RX_EN] <= 1'b0;
		end
	end

endmodule

/* sources.f */
+incdir+test
source/uart_axi_pkg.sv
source/axi_lite_slave.sv
source/uart_regs.sv
source/byte_fifo.sv
source/uart_axi_top.sv
test/tb_uart_axi.sv

/* test/tb_uart_axi_tasks.svh */
function automatic logic [31:0] reg_addr(input reg_idx_t idx);
	return UART_BASE_ADDR + {28'd0, idx, 2'b00};
endfunction

task automatic write_access(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input axi_resp_t want);
	@(posedge clk);
	awaddr  <= addr;
	wdata   <= data;
	wstrb   <= strb;
	awvalid <= 1'b1;
	wvalid  <= 1'b1;
	do @(negedge clk); while (!awready);
	if (!wready) count_failure("wready did not rise together with awready");
	@(posedge clk);
	awvalid <= 1'b0;
	wvalid  <= 1'b0;
	do @(negedge clk); while (!bvalid);
	if (bresp !== want) log_mismatch("s_axi_bresp_o", {30'd0, bresp}, {30'd0, want});
endtask

task automatic read_access(input logic [31:0] addr, input axi_resp_t want,
		output logic [31:0] data);
	@(posedge clk);
	araddr  <= addr;
	arvalid <= 1'b1;
	do @(negedge clk); while (!arready);
	@(posedge clk);
	arvalid <= 1'b0;
	do @(negedge clk); while (!rvalid);
	data = rdata;
	if (rresp !== want) log_mismatch("s_axi_rresp_o", {30'd0, rresp}, {30'd0, want});
endtask

task automatic verify_reset_state();
	logic [31:0] data;
	@(negedge clk);
	if ({tx_en, rx_en} !== 2'b00)
		log_mismatch("{tx_en_o, rx_en_o}", {30'd0, tx_en, rx_en}, 32'd0);
	read_access(reg_addr(REG_STATUS), RESP_OKAY, data);
	if (data !== 32'h0000_000a) log_mismatch("s_axi_rdata_o", data, 32'h0000_000a);
	read_access(reg_addr(REG_CTRL), RESP_OKAY, data);
	if (data !== 32'd0) log_mismatch("s_axi_rdata_o", data, 32'd0);
endtask

task automatic strobed_ctrl_write();
	logic [31:0] word;
	logic [31:0] data;
	word = $urandom();
	write_access(reg_addr(REG_CTRL), word, 4'b0101, RESP_OKAY);
	read_access(reg_addr(REG_CTRL), RESP_OKAY, data);
	// bytes 1 and 3 keep their reset value
	if (data !== {8'h00, word[23:16], 8'h00, word[7:0]})
		log_mismatch("s_axi_rdata_o", data, {8'h00, word[23:16], 8'h00, word[7:0]});
	if (baud_div !== {8'h00, word[23:16]})
		log_mismatch("baud_div_o", {16'd0, baud_div}, {24'd0, word[23:16]});
endtask

task automatic transmit_path();
	logic [7:0]  sent[$];
	logic [31:0] word;
	logic [31:0] data;
	int unsigned count;
	count = $urandom_range(FIFO_DEPTH, FIFO_DEPTH / 2);
	tx_log.delete();
	write_access(reg_addr(REG_CTRL), 32'd0, 4'b0001, RESP_OKAY); // both enables off
	for (int i = 0; i < count; i++) begin
		word = $urandom();
		sent.push_back(word[7:0]); // only the low byte gets pushed
		write_access(reg_addr(REG_WDATA), word, 4'b1111, RESP_OKAY);
	end
	write_access(reg_addr(REG_CTRL), 32'd1, 4'b0001, RESP_OKAY);
	repeat (count) finish_tx_byte();
	repeat (2) @(posedge clk);
	@(negedge clk);
	if (tx_log.size() != count) count_failure("tx_o byte count differs from bytes written");
	for (int i = 0; i < tx_log.size() && i < count; i++) begin
		if (tx_log[i] !== sent[i]) log_mismatch("tx_o", {24'd0, tx_log[i]}, {24'd0, sent[i]});
	end
	if (tx_en !== 1'b0) log_mismatch("tx_en_o", {31'd0, tx_en}, 32'd0);
	read_access(reg_addr(REG_STATUS), RESP_OKAY, data);
	if (data[ST_TX_EMPTY:ST_TX_FULL] !== 2'b10)
		log_mismatch("s_axi_rdata_o[1:0]", {30'd0, data[1:0]}, 32'd2);
endtask

task automatic receive_path();
	logic [7:0]  recv[$];
	logic [31:0] word;
	logic [31:0] data;
	write_access(reg_addr(REG_CTRL), 32'd2, 4'b0001, RESP_OKAY); // rx on, tx off
	repeat (6) begin
		word = $urandom();
		recv.push_back(word[7:0]);
		deliver_rx_byte(word[7:0]);
	end
	foreach (recv[i]) begin
		read_access(reg_addr(REG_RDATA), RESP_OKAY, data);
		if (data !== {24'd0, recv[i]}) log_mismatch("s_axi_rdata_o", data, {24'd0, recv[i]});
	end
	read_access(reg_addr(REG_RDATA), RESP_SLVERR, data); // nothing left to pop
	repeat (FIFO_DEPTH) begin
		word = $urandom();
		deliver_rx_byte(word[7:0]);
	end
	repeat (2) @(posedge clk);
	@(negedge clk);
	if (rx_en !== 1'b0) log_mismatch("rx_en_o", {31'd0, rx_en}, 32'd0);
	read_access(reg_addr(REG_STATUS), RESP_OKAY, data);
	if (data[ST_RX_EMPTY:ST_RX_FULL] !== 2'b01)
		log_mismatch("s_axi_rdata_o[3:2]", {30'd0, data[3:2]}, 32'd1);
endtask

task automatic overflow_and_illegal();
	logic [31:0] word;
	logic [31:0] data;
	logic [31:0] ctrl_before;
	write_access(reg_addr(REG_CTRL), 32'd0, 4'b0001, RESP_OKAY); // tx off, nothing drains
	repeat (FIFO_DEPTH) begin
		word = $urandom();
		write_access(reg_addr(REG_WDATA), word, 4'b0001, RESP_OKAY);
	end
	read_access(reg_addr(REG_STATUS), RESP_OKAY, data);
	if (data[ST_TX_FULL] !== 1'b1) log_mismatch("s_axi_rdata_o[0]", {31'd0, data[0]}, 32'd1);
	write_access(reg_addr(REG_WDATA), 32'h5a, 4'b0001, RESP_SLVERR);
	write_access(reg_addr(REG_STATUS), 32'hf, 4'b1111, RESP_SLVERR);
	write_access(reg_addr(REG_RDATA), 32'hf, 4'b1111, RESP_SLVERR);
	read_access(reg_addr(REG_WDATA), RESP_SLVERR, data);
	read_access(reg_addr(REG_CTRL), RESP_OKAY, ctrl_before);
	// offset 0x10 lands on index 0, the control register
	write_access(UART_BASE_ADDR + 32'h10, 32'hffff_ffff, 4'b1111, RESP_SLVERR);
	// address bits 3:2 decode to the status index
	read_access(UART_BASE_ADDR - 32'hC, RESP_SLVERR, data);
	if (data !== 32'd0) log_mismatch("s_axi_rdata_o", data, 32'd0);
	read_access(reg_addr(REG_CTRL), RESP_OKAY, data);
	if (data !== ctrl_before) log_mismatch("s_axi_rdata_o", data, ctrl_before);
endtask

/* test/tb_uart_axi.sv */
module tb_uart_axi;
	import uart_axi_pkg::*;

	localparam logic [31:0] UART_BASE_ADDR = 32'h2000_0000;
	localparam int unsigned FIFO_DEPTH     = 32;
	// tests take roughly 14 cycles per buffer slot plus 200
	localparam int unsigned TIMEOUT_CYCLES = 20 * (14 * FIFO_DEPTH + 200) + 500;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic [31:0] awaddr = '0, wdata = '0, araddr = '0;
	logic [3:0]  wstrb = '0;
	logic        awvalid = 1'b0, wvalid = 1'b0, arvalid = 1'b0;
	logic        bready = 1'b1, rready = 1'b1; // master always takes responses
	logic        t_done = 1'b0, r_done = 1'b0;
	logic [7:0]  rx_byte = '0;
	logic [31:0] rdata;
	logic        awready, wready, bvalid, arready, rvalid, tx_en, rx_en;
	axi_resp_t   bresp, rresp;
	logic [7:0]  tx_byte;
	logic [15:0] baud_div;
	int unsigned seed = 32'h08ef8fda;
	int unsigned value_errors = 0, other_errors = 0, cycle_count = 0;
	logic [7:0]  tx_log[$]; // tx_o seen at each t_done pulse

	always #50 clk = ~clk;

	uart_axi_top #(.UART_BASE_ADDR(UART_BASE_ADDR), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
		.s_axi_aclk_i(clk), .s_axi_aresetn_i(rst),
		.s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_wdata_i(wdata),
		.s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid), .s_axi_bready_i(bready),
		.s_axi_awready_o(awready), .s_axi_wready_o(wready), .s_axi_bvalid_o(bvalid),
		.s_axi_bresp_o(bresp), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
		.s_axi_rready_i(rready), .s_axi_arready_o(arready), .s_axi_rvalid_o(rvalid),
		.s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
		.t_done_i(t_done), .r_done_i(r_done), .rx_i(rx_byte),
		.tx_en_o(tx_en), .rx_en_o(rx_en), .tx_o(tx_byte), .baud_div_o(baud_div)
	);

	task automatic log_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		value_errors++;
		$display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
	endtask

	task automatic count_failure(input string what);
		other_errors++;
		$display("failure at %0t: %s", $time, what);
	endtask

	task automatic close_run();
		$display("%0d value errors, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// uart finished sending the head byte
	task automatic finish_tx_byte();
		@(posedge clk);
		t_done <= 1'b1;
		@(negedge clk);
		tx_log.push_back(tx_byte);
		@(posedge clk);
		t_done <= 1'b0;
	endtask

	task automatic deliver_rx_byte(input logic [7:0] data);
		@(posedge clk);
		r_done  <= 1'b1;
		rx_byte <= data;
		@(posedge clk);
		r_done <= 1'b0;
	endtask

	`include "tb_uart_axi_tasks.svh"

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			count_failure("timeout, the tests did not finish in time");
			close_run();
		end
	end

	initial begin
		void'($urandom(seed));
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		verify_reset_state();
		strobed_ctrl_write();
		transmit_path();
		receive_path();
		overflow_and_illegal();
		repeat (2) @(posedge clk);
		close_run();
	end

endmodule
